// ==== gpio_config.svh ====
`ifndef GPIO_CONFIG_SVH
`define GPIO_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// byte address, covers both banks plus the unmapped space above
`define TCB_ADR_W 12
// data word
`define TCB_DAT_W 32

//////////////////////////////////////////////////////////////////////
// GPIO banks
//////////////////////////////////////////////////////////////////////

// bank pin counts
`define GPIO0_W 16
`define GPIO1_W 8
// input synchronizer depth, 0 bypasses
`define GPIO_CDC_STAGES 2

`endif

// ==== gpio_pkg.sv ====
`default_nettype none

`include "gpio_config.svh"

package gpio_pkg;

  //////////////////////////////////////////////////////////////////////
  // width types
  //////////////////////////////////////////////////////////////////////

  // byte address on the bus
  typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

  // one data word
  typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

  //////////////////////////////////////////////////////////////////////
  // bus channel structs
  //////////////////////////////////////////////////////////////////////

  // request, sampled in every cycle with vld high
  typedef struct packed {
    // write enable, read otherwise
    logic     wen;
    // byte address
    tcb_adr_t adr;
    // write data
    tcb_dat_t wdt;
  } tcb_req_t;

  // response, presented one cycle after the request
  typedef struct packed {
    // read data
    tcb_dat_t rdt;
    // status, 1 for an unmapped address
    logic     sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire

// ==== gpio_sync.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module gpio_sync #(
  parameter int unsigned GW = 32
) (
  input  logic          tcb,
  input  logic          arst_n,
  input  logic [GW-1:0] async_in,
  output logic [GW-1:0] sync_out
);

  // number of flip-flop stages
  localparam int unsigned STAGES = `GPIO_CDC_STAGES;

  generate
    if (STAGES > 0) begin : gen_sync
      // stage 0 samples the pins, last stage feeds the bank
      logic [STAGES-1:0][GW-1:0] stg;

      always_ff @(posedge tcb or negedge arst_n) begin
        if (!arst_n) begin
          stg <= '0;
        end else begin
          stg[0] <= async_in;
          // shift along the chain
          for (int i = 1; i < STAGES; i++) begin
            stg[i] <= stg[i-1];
          end
        end
      end

      assign sync_out = stg[STAGES-1];
    end else begin : gen_bypass
      // no stages, inputs already in the bus clock domain
      assign sync_out = async_in;
    end
  endgenerate

endmodule

`default_nettype wire

// ==== gpio_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module gpio_regs #(
  parameter int unsigned GW = 32
) (
  input  logic                tcb,
  input  logic                arst_n,
  // bank select from the decoder, already qualified by vld
  input  logic                sel,
  input  gpio_pkg::tcb_req_t  req,
  output gpio_pkg::tcb_dat_t  rdt,
  // pin side
  output logic [GW-1:0]       gpio_o,
  output logic [GW-1:0]       gpio_e,
  // synchronized input value
  input  logic [GW-1:0]       gpio_r
);

  //////////////////////////////////////////////////////////////////////
  // elaboration checks
  //////////////////////////////////////////////////////////////////////

  // bank must fit into one data word
  if (GW > `TCB_DAT_W) begin : gen_chk_width
    $error("gpio_regs: GW %0d exceeds the data width %0d", GW, `TCB_DAT_W);
  end

  //////////////////////////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////////////////////////

  // word offsets inside the bank
  localparam logic [3:0] OFS_OUT = 4'h0;
  localparam logic [3:0] OFS_ENA = 4'h4;
  localparam logic [3:0] OFS_INP = 4'h8;

  // low address bits pick the word
  logic [3:0] ofs;

  assign ofs = req.adr[3:0];

  //////////////////////////////////////////////////////////////////////
  // write access
  //////////////////////////////////////////////////////////////////////

  // output and enable registers, pins undriven after reset
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (sel && req.wen) begin
      case (ofs)
        // write data cut down to the bank width
        OFS_OUT: gpio_o <= req.wdt[GW-1:0];
        OFS_ENA: gpio_e <= req.wdt[GW-1:0];
        // input word is read only, other offsets ignored
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read access
  //////////////////////////////////////////////////////////////////////

  // combinational read, upper bits stay zero
  always_comb begin
    rdt = '0;
    case (ofs)
      OFS_OUT: rdt[GW-1:0] = gpio_o;
      OFS_ENA: rdt[GW-1:0] = gpio_e;
      OFS_INP: rdt[GW-1:0] = gpio_r;
      // undefined offsets read as zero
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== tcb_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module tcb_decoder (
  input  logic               vld,
  input  gpio_pkg::tcb_req_t req,
  // bank selects
  output logic               sel0,
  output logic               sel1,
  // bank read words
  input  gpio_pkg::tcb_dat_t rdt0,
  input  gpio_pkg::tcb_dat_t rdt1,
  // response before the output register
  output gpio_pkg::tcb_rsp_t rsp
);

  import gpio_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // address above both banks
  logic     oor;
  // bank index
  logic     bank;
  // read word of the addressed bank
  tcb_dat_t bank_rdt;

  // bits 11 to 5 must be zero
  assign oor  = |req.adr[`TCB_ADR_W-1:5];
  assign bank = req.adr[4];

  // one select at most, none for unmapped access
  assign sel0 = vld && !oor && !bank;
  assign sel1 = vld && !oor && bank;

  //////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////

  assign bank_rdt = bank ? rdt1 : rdt0;

  // unmapped reads return zero with error status
  assign rsp.rdt = oor ? '0 : bank_rdt;
  assign rsp.sts = oor;

endmodule

`default_nettype wire

// ==== tcb_rsp_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module tcb_rsp_reg (
  input  logic               tcb,
  input  logic               arst_n,
  // request valid, marks a transfer cycle
  input  logic               vld,
  // response from the decoder
  input  gpio_pkg::tcb_rsp_t rsp_d,
  // response one cycle later
  output logic               rsp_vld,
  output gpio_pkg::tcb_rsp_t rsp
);

  //////////////////////////////////////////////////////////////////////
  // response valid
  //////////////////////////////////////////////////////////////////////

  // follows vld every cycle, fixed delay of one
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response payload
  //////////////////////////////////////////////////////////////////////

  // loaded on transfer cycles only
  // idle cycles keep the last response on the bus
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rsp <= '0;
    end else if (vld) begin
      rsp <= rsp_d;
    end
  end

endmodule

`default_nettype wire

// ==== gpio_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module gpio_subsys (
  input  logic                  tcb,
  input  logic                  arst_n,
  // bus request
  input  logic                  vld,
  input  gpio_pkg::tcb_req_t    req,
  // bus response
  output logic                  rsp_vld,
  output gpio_pkg::tcb_rsp_t    rsp,
  // bank 0 pins
  output logic [`GPIO0_W-1:0]   gpio0_o,
  output logic [`GPIO0_W-1:0]   gpio0_e,
  input  logic [`GPIO0_W-1:0]   gpio0_i,
  // bank 1 pins
  output logic [`GPIO1_W-1:0]   gpio1_o,
  output logic [`GPIO1_W-1:0]   gpio1_e,
  input  logic [`GPIO1_W-1:0]   gpio1_i
);

  import gpio_pkg::*;

  // decoder to banks
  logic     sel0;
  logic     sel1;
  tcb_dat_t rdt0;
  tcb_dat_t rdt1;
  // unregistered response
  tcb_rsp_t rsp_d;
  // synchronized pin inputs
  logic [`GPIO0_W-1:0] gpio0_r;
  logic [`GPIO1_W-1:0] gpio1_r;

  //////////////////////////////////////////////////////////////////////
  // bus decode and response
  //////////////////////////////////////////////////////////////////////

  tcb_decoder tcb_decoder_inst (
    .vld  (vld),
    .req  (req),
    .sel0 (sel0),
    .sel1 (sel1),
    .rdt0 (rdt0),
    .rdt1 (rdt1),
    .rsp  (rsp_d)
  );

  tcb_rsp_reg tcb_rsp_reg_inst (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .vld     (vld),
    .rsp_d   (rsp_d),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // bank 0
  //////////////////////////////////////////////////////////////////////

  gpio_sync #(.GW(`GPIO0_W)) gpio0_sync_inst (
    .tcb      (tcb),
    .arst_n   (arst_n),
    .async_in (gpio0_i),
    .sync_out (gpio0_r)
  );

  gpio_regs #(.GW(`GPIO0_W)) gpio0_regs_inst (
    .tcb    (tcb),
    .arst_n (arst_n),
    .sel    (sel0),
    .req    (req),
    .rdt    (rdt0),
    .gpio_o (gpio0_o),
    .gpio_e (gpio0_e),
    .gpio_r (gpio0_r)
  );

  //////////////////////////////////////////////////////////////////////
  // bank 1
  //////////////////////////////////////////////////////////////////////

  gpio_sync #(.GW(`GPIO1_W)) gpio1_sync_inst (
    .tcb      (tcb),
    .arst_n   (arst_n),
    .async_in (gpio1_i),
    .sync_out (gpio1_r)
  );

  gpio_regs #(.GW(`GPIO1_W)) gpio1_regs_inst (
    .tcb    (tcb),
    .arst_n (arst_n),
    .sel    (sel1),
    .req    (req),
    .rdt    (rdt1),
    .gpio_o (gpio1_o),
    .gpio_e (gpio1_e),
    .gpio_r (gpio1_r)
  );

endmodule

`default_nettype wire

// ==== gpio_subsys_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module gpio_subsys_assert (
  input logic                tcb,
  input logic                arst_n,
  input logic                vld,
  input gpio_pkg::tcb_req_t  req,
  input logic                rsp_vld,
  input gpio_pkg::tcb_rsp_t  rsp,
  input logic [`GPIO0_W-1:0] gpio0_o,
  input logic [`GPIO0_W-1:0] gpio0_e,
  input logic [`GPIO1_W-1:0] gpio1_o,
  input logic [`GPIO1_W-1:0] gpio1_e,
  // expected response of the request in this cycle
  input gpio_pkg::tcb_rsp_t  exp_rsp,
  // expected pin state after the request in this cycle
  input logic [`GPIO0_W-1:0] exp0_o,
  input logic [`GPIO0_W-1:0] exp0_e,
  input logic [`GPIO1_W-1:0] exp1_o,
  input logic [`GPIO1_W-1:0] exp1_e
);

  import gpio_pkg::*;

  // failed checks so far
  int unsigned fail_cnt = 0;
  // request above both banks
  logic oor;

  assign oor = |req.adr[`TCB_ADR_W-1:5];

  //////////////////////////////////////////////////////////////////////
  // bus protocol
  //////////////////////////////////////////////////////////////////////

  // quiet outputs while in reset
  a_reset: assert property (@(posedge tcb)
    !arst_n |-> (!rsp_vld && rsp == '0 && {gpio0_o, gpio0_e, gpio1_o, gpio1_e} == '0))
    else begin
      $error("ERROR %0t: outputs not zero in reset", $time);
      fail_cnt++;
    end

  // one response per request, one cycle later
  a_rsp_vld: assert property (@(posedge tcb) disable iff (!arst_n)
    rsp_vld == $past(vld))
    else begin
      $error("ERROR %0t: rsp_vld does not follow vld", $time);
      fail_cnt++;
    end

  // error status only for unmapped addresses
  a_sts: assert property (@(posedge tcb) disable iff (!arst_n)
    vld |=> rsp.sts == $past(oor))
    else begin
      $error("ERROR %0t: wrong sts", $time);
      fail_cnt++;
    end

  //////////////////////////////////////////////////////////////////////
  // data checks
  //////////////////////////////////////////////////////////////////////

  a_rsp: assert property (@(posedge tcb) disable iff (!arst_n)
    vld |=> rsp == $past(exp_rsp))
    else begin
      $error("ERROR %0t: rsp %h, expected %h", $time, rsp, $past(exp_rsp));
      fail_cnt++;
    end

  // bits above the bank width read as zero
  a_upper0: assert property (@(posedge tcb) disable iff (!arst_n)
    vld && !oor && !req.adr[4] |=> rsp.rdt[`TCB_DAT_W-1:`GPIO0_W] == '0)
    else begin
      $error("ERROR %0t: bank 0 upper read bits set", $time);
      fail_cnt++;
    end

  a_upper1: assert property (@(posedge tcb) disable iff (!arst_n)
    vld && !oor && req.adr[4] |=> rsp.rdt[`TCB_DAT_W-1:`GPIO1_W] == '0)
    else begin
      $error("ERROR %0t: bank 1 upper read bits set", $time);
      fail_cnt++;
    end

  // pins follow a write one cycle later
  a_pins: assert property (@(posedge tcb) disable iff (!arst_n)
    {gpio0_o, gpio0_e, gpio1_o, gpio1_e} == $past({exp0_o, exp0_e, exp1_o, exp1_e}))
    else begin
      $error("ERROR %0t: pin state differs from expected", $time);
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== gpio_subsys_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "gpio_config.svh"

module gpio_subsys_tb;

  import gpio_pkg::*;

  // response wait limit in cycles
  localparam int TMO = 8;

  logic                tcb = 1'b0;
  logic                arst_n;
  logic                vld;
  tcb_req_t            req;
  logic                rsp_vld;
  tcb_rsp_t            rsp;
  logic [`GPIO0_W-1:0] gpio0_o;
  logic [`GPIO0_W-1:0] gpio0_e;
  logic [`GPIO0_W-1:0] gpio0_i;
  logic [`GPIO1_W-1:0] gpio1_o;
  logic [`GPIO1_W-1:0] gpio1_e;
  logic [`GPIO1_W-1:0] gpio1_i;

  // register model per bank, already cut to the bank width
  tcb_dat_t    mdl_o [2] = '{default: '0};
  tcb_dat_t    mdl_e [2] = '{default: '0};
  tcb_dat_t    mdl_i [2] = '{default: '0};
  tcb_rsp_t    exp_rsp;
  logic        abort = 1'b0;
  int unsigned fail_seen = 0;
  int          n_test = 0;
  int          n_pass = 0;
  int          n_fail = 0;

  always #20 tcb = ~tcb;

  gpio_subsys gpio_subsys_inst (.*);

  bind gpio_subsys gpio_subsys_assert gpio_subsys_assert_inst (
    .*,
    .exp_rsp (gpio_subsys_tb.exp_rsp),
    .exp0_o  (gpio_subsys_tb.mdl_o[0][`GPIO0_W-1:0]),
    .exp0_e  (gpio_subsys_tb.mdl_e[0][`GPIO0_W-1:0]),
    .exp1_o  (gpio_subsys_tb.mdl_o[1][`GPIO1_W-1:0]),
    .exp1_e  (gpio_subsys_tb.mdl_e[1][`GPIO1_W-1:0])
  );

  //////////////////////////////////////////////////////////////////////
  // reference model and bus tasks
  //////////////////////////////////////////////////////////////////////

  function automatic tcb_dat_t bank_mask(logic bank);
    return bank ? {`GPIO1_W{1'b1}} : {`GPIO0_W{1'b1}};
  endfunction

  // read word of the current model state
  function automatic tcb_rsp_t expect_rsp(tcb_adr_t adr);
    tcb_rsp_t r;
    r = '0;
    if (|adr[`TCB_ADR_W-1:5]) begin
      r.sts = 1'b1;
    end else begin
      case (adr[3:0])
        4'h0: r.rdt = mdl_o[adr[4]];
        4'h4: r.rdt = mdl_e[adr[4]];
        4'h8: r.rdt = mdl_i[adr[4]];
        default: r.rdt = '0;
      endcase
    end
    return r;
  endfunction

  // one request in this cycle, model follows the write
  task automatic drive_req(logic wen, tcb_adr_t adr, tcb_dat_t wdt);
    vld     <= 1'b1;
    req     <= '{wen, adr, wdt};
    exp_rsp <= expect_rsp(adr);
    if (wen && !(|adr[`TCB_ADR_W-1:5])) begin
      if (adr[3:0] == 4'h0) mdl_o[adr[4]] = wdt & bank_mask(adr[4]);
      if (adr[3:0] == 4'h4) mdl_e[adr[4]] = wdt & bank_mask(adr[4]);
    end
  endtask

  // sample on the falling edge, response is stable there
  task automatic wait_rsp();
    int n;
    n = 0;
    do begin
      @(negedge tcb);
      n++;
    end while (!rsp_vld && n < TMO);
    if (!rsp_vld) begin
      $display("timeout at %0t: no response within %0d cycles", $time, TMO);
      abort = 1'b1;
    end
    @(posedge tcb);
  endtask

  task automatic xfer(logic wen, tcb_adr_t adr, tcb_dat_t wdt);
    if (abort) return;
    drive_req(wen, adr, wdt);
    @(posedge tcb);
    vld <= 1'b0;
    wait_rsp();
  endtask

  // one more edge so the last response has been checked
  task automatic end_test(string name);
    @(posedge tcb);
    n_test++;
    if (abort || gpio_subsys_inst.gpio_subsys_assert_inst.fail_cnt != fail_seen) begin
      $display("test %0d %s: failed", n_test, name);
      n_fail++;
    end else begin
      $display("test %0d %s: passed", n_test, name);
      n_pass++;
    end
    fail_seen = gpio_subsys_inst.gpio_subsys_assert_inst.fail_cnt;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    tcb_adr_t    adr;
    tcb_dat_t    val;
    void'($urandom(76));
    arst_n  <= 1'b0;
    vld     <= 1'b0;
    req     <= '0;
    exp_rsp <= '0;
    gpio0_i <= '0;
    gpio1_i <= '0;
    repeat (2) @(posedge tcb);
    arst_n <= 1'b1;
    @(posedge tcb);

    // reset values of both banks
    xfer(1'b0, 12'h000, '0);
    xfer(1'b0, 12'h004, '0);
    xfer(1'b0, 12'h010, '0);
    xfer(1'b0, 12'h014, '0);
    end_test("reset values");

    // random writes, each read back
    repeat (8) begin
      adr = {7'h0, 1'($urandom), 4'($urandom_range(0, 1) * 4)};
      xfer(1'b1, adr, $urandom);
      xfer(1'b0, adr, '0);
    end
    end_test("output and enable writes");

    // held inputs pass the synchronizer, input word ignores writes
    val = $urandom;
    gpio0_i <= val[`GPIO0_W-1:0];
    mdl_i[0] = val & bank_mask(1'b0);
    val = $urandom;
    gpio1_i <= val[`GPIO1_W-1:0];
    mdl_i[1] = val & bank_mask(1'b1);
    repeat (3) @(posedge tcb);
    xfer(1'b0, 12'h008, '0);
    xfer(1'b0, 12'h018, '0);
    xfer(1'b1, 12'h008, $urandom);
    xfer(1'b1, 12'h018, $urandom);
    xfer(1'b0, 12'h008, '0);
    xfer(1'b0, 12'h018, '0);
    end_test("input read");

    // unmapped writes to output and enable words of both banks, then reads
    for (int k = 0; k < 8; k++) begin
      adr = {7'($urandom_range(1, 127)), k[0], k[2:1], 2'b00};
      xfer(!k[2], adr, $urandom);
    end
    xfer(1'b0, 12'h000, '0);
    xfer(1'b0, 12'h004, '0);
    xfer(1'b0, 12'h010, '0);
    xfer(1'b0, 12'h014, '0);
    end_test("unmapped access");

    // one transfer per cycle, about one in six unmapped
    repeat (12) begin
      adr = {7'h0, 1'($urandom), 4'($urandom_range(0, 3) * 4)};
      if ($urandom_range(0, 5) == 0) adr[`TCB_ADR_W-1:5] = 7'($urandom_range(1, 127));
      drive_req(1'($urandom), adr, $urandom);
      @(posedge tcb);
    end
    vld <= 1'b0;
    wait_rsp();
    end_test("back-to-back transfers");

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0 && !abort) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gpio_subsys.f ====
+incdir+.
gpio_pkg.sv
gpio_sync.sv
gpio_regs.sv
tcb_decoder.sv
tcb_rsp_reg.sv
gpio_subsys.sv
gpio_subsys_assert.sv
gpio_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: gpio_subsys

export_include_dirs:
  - .

sources:
  - gpio_pkg.sv
  - gpio_sync.sv
  - gpio_regs.sv
  - tcb_decoder.sv
  - tcb_rsp_reg.sv
  - gpio_subsys.sv
  - target: test
    files:
      - gpio_subsys_assert.sv
      - gpio_subsys_tb.sv
